/* design/chdr_pkg.sv */
// shared types for the two-channel ingress checker
package chdr_pkg;

    // widths that carry a meaning
    typedef logic [31:0] chdr_word_t;   // one stream word
    typedef logic [15:0] len_t;         // length in bytes or in words
    typedef logic [11:0] seq_t;         // header sequence number
    typedef logic [15:0] cnt_t;         // saturating error count
    typedef logic [7:0]  apb_addr_t;    // register byte address

    // one stream beat, travels next to a valid/ready pair
    typedef struct packed {
        chdr_word_t data;
        logic       last;   // last word of the packet
        logic       err;    // packet is to be discarded by the gate
    } axis_beat_t;

    // single cycle error flags from a frame checker
    typedef struct packed {
        logic len_err;      // header length is obviously bad
        logic eof_err;      // marked last word came without the last flag
        logic seq_err;      // sequence number gap
    } err_pulse_t;

    // apb request side, pready/pslverr/prdata come back separately
    typedef struct packed {
        logic       psel;
        logic       penable;
        logic       pwrite;
        apb_addr_t  paddr;
        chdr_word_t pwdata;
    } apb_req_t;

    // frame checker states
    typedef enum logic [1:0] {
        HDR  = 2'd0,    // expecting a header
        FWD  = 2'd1,    // forwarding body words
        EOF  = 2'd2,    // next word must be the last one
        WAIT = 2'd3     // resync, drop until a last flag
    } checker_state_e;

    // register map
    localparam apb_addr_t ADDR_CTRL    = 8'h00;  // bit 0 = clear, write only
    localparam apb_addr_t ADDR_CH0_LEN = 8'h04;
    localparam apb_addr_t ADDR_CH0_EOF = 8'h08;
    localparam apb_addr_t ADDR_CH0_SEQ = 8'h0C;
    localparam apb_addr_t ADDR_CH1_LEN = 8'h10;
    localparam apb_addr_t ADDR_CH1_EOF = 8'h14;
    localparam apb_addr_t ADDR_CH1_SEQ = 8'h18;

endpackage

/* design/chdr_frame_checker.sv */
`timescale 1ns/1ns
// checks header length and sequence of one input channel
// drops input that lost packet alignment and flags bad packets for the gate
module chdr_frame_checker #(
    parameter int SIZE = 9                  // max packet is 2**SIZE words
) (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_clear,
    input  chdr_pkg::axis_beat_t  i_beat,
    input  logic                  i_valid,
    output logic                  o_ready,
    output chdr_pkg::axis_beat_t  o_beat,
    output logic                  o_valid,
    input  logic                  i_ready,
    output chdr_pkg::err_pulse_t  o_err
);

    localparam logic [16:0] MAX_WORDS = 17'd1 << SIZE;

    chdr_pkg::checker_state_e state;
    chdr_pkg::len_t           words_left;   // words still due, incl. current
    chdr_pkg::seq_t           seq_exp;      // expected sequence number

    logic [16:0]    hdr_bytes_up;           // 17 bits so 0xffff+3 does not wrap
    chdr_pkg::len_t hdr_words;
    chdr_pkg::seq_t hdr_seq;
    logic           hdr_bad;
    logic           hdr_take;
    logic           xfer;
    logic           miss_last;

    // header fields, only meaningful in HDR
    assign hdr_bytes_up = {1'b0, i_beat.data[15:0]} + 17'd3;    // round up to words
    assign hdr_words    = {1'b0, hdr_bytes_up[16:2]};
    assign hdr_seq      = i_beat.data[27:16];
    assign hdr_bad      = (hdr_words == 16'd0) || ({1'b0, hdr_words} > MAX_WORDS);

    assign o_ready  = i_ready;              // stall straight from the gate
    assign xfer     = i_valid && i_ready;
    assign hdr_take = (state == chdr_pkg::HDR) && xfer && !hdr_bad;

    // word marked last by the length but no last flag on the input
    always_comb begin
        miss_last = 1'b0;
        if (state == chdr_pkg::EOF)
            miss_last = !i_beat.last;
        else if (state == chdr_pkg::HDR)
            miss_last = !hdr_bad && (hdr_words == 16'd1) && !i_beat.last;
    end

    // output beat, zero latency toward the gate
    always_comb begin
        o_beat.data = i_beat.data;
        o_beat.last = 1'b0;
        o_beat.err  = miss_last;            // gate rewinds on this
        o_valid     = 1'b0;
        case (state)
            chdr_pkg::HDR: begin
                o_beat.last = (hdr_words == 16'd1);
                o_valid     = i_valid && !hdr_bad;  // bad header never reaches the gate
            end
            chdr_pkg::FWD: begin
                o_valid = i_valid;          // input last flag ignored mid packet
            end
            chdr_pkg::EOF: begin
                o_beat.last = 1'b1;         // forced so the gate sees a boundary
                o_valid     = i_valid;
            end
            default: begin
                o_valid = 1'b0;             // WAIT drops everything
            end
        endcase
    end

    // error pulses in the cycle of the offending transfer
    assign o_err.len_err = (state == chdr_pkg::HDR) && xfer && hdr_bad;
    assign o_err.eof_err = xfer && miss_last;
    assign o_err.seq_err = hdr_take && (hdr_seq != seq_exp);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= chdr_pkg::HDR;
            words_left <= '0;
            seq_exp    <= '0;
        end else if (i_clear) begin
            state      <= chdr_pkg::HDR;
            words_left <= '0;
            seq_exp    <= '0;
        end else if (xfer) begin
            case (state)
                chdr_pkg::HDR: begin
                    words_left <= hdr_words;
                    if (hdr_bad)
                        state <= chdr_pkg::WAIT;    // lost alignment
                    else if (hdr_words == 16'd1)
                        state <= miss_last ? chdr_pkg::WAIT : chdr_pkg::HDR;
                    else if (hdr_words == 16'd2)
                        state <= chdr_pkg::EOF;
                    else
                        state <= chdr_pkg::FWD;
                    if (!hdr_bad)
                        seq_exp <= hdr_seq + 12'd1; // resync to what came in
                end
                chdr_pkg::FWD: begin
                    if (words_left == 16'd3)
                        state <= chdr_pkg::EOF;     // next word is the last one
                    words_left <= words_left - 16'd1;
                end
                chdr_pkg::EOF: begin
                    state <= i_beat.last ? chdr_pkg::HDR : chdr_pkg::WAIT;
                end
                default: begin
                    if (i_beat.last)
                        state <= chdr_pkg::HDR;     // next word taken as a header
                end
            endcase
        end
    end

endmodule

/* design/chdr_packet_gate.sv */
`timescale 1ns/1ns
// whole packet buffer
// words become visible to the read side only after the last word is in
// a packet flagged with err is thrown away by rewinding the write pointer
module chdr_packet_gate #(
    parameter int SIZE = 9                  // depth is 2**SIZE words
) (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_clear,
    input  chdr_pkg::axis_beat_t  i_beat,
    input  logic                  i_valid,
    output logic                  o_ready,
    output chdr_pkg::axis_beat_t  o_beat,
    output logic                  o_valid,
    input  logic                  i_ready
);

    localparam int DEPTH = 1 << SIZE;

    // storage, the err flag is not kept since bad packets never commit
    chdr_pkg::chdr_word_t mem_data [DEPTH];
    logic                 mem_last [DEPTH];

    // one extra bit to tell full from empty
    logic [SIZE:0] wr_ptr;
    logic [SIZE:0] cmt_ptr;                 // end of the last good packet
    logic [SIZE:0] rd_ptr;

    logic err_seen;                         // err seen earlier in this packet
    logic full;
    logic wr_en;
    logic rd_en;
    logic drop;

    assign full  = (wr_ptr[SIZE] != rd_ptr[SIZE]) &&
                   (wr_ptr[SIZE-1:0] == rd_ptr[SIZE-1:0]);
    assign o_ready = !full;                 // only full holds off the writer
    assign wr_en   = i_valid && !full;
    assign drop    = err_seen || i_beat.err;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_data[wr_ptr[SIZE-1:0]] <= i_beat.data;
            mem_last[wr_ptr[SIZE-1:0]] <= i_beat.last;
        end
    end

    // read side, committed words only
    assign o_valid     = (rd_ptr != cmt_ptr);
    assign o_beat.data = mem_data[rd_ptr[SIZE-1:0]];
    assign o_beat.last = mem_last[rd_ptr[SIZE-1:0]];
    assign o_beat.err  = 1'b0;              // errored packets never get here
    assign rd_en       = o_valid && i_ready;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr   <= '0;
            cmt_ptr  <= '0;
            rd_ptr   <= '0;
            err_seen <= 1'b0;
        end else if (i_clear) begin
            wr_ptr   <= '0;
            cmt_ptr  <= '0;
            rd_ptr   <= '0;
            err_seen <= 1'b0;
        end else begin
            if (wr_en) begin
                if (i_beat.last) begin
                    err_seen <= 1'b0;
                    if (drop) begin
                        wr_ptr <= cmt_ptr;          // rewind, packet discarded
                    end else begin
                        wr_ptr  <= wr_ptr + 1'b1;
                        cmt_ptr <= wr_ptr + 1'b1;   // release the whole packet
                    end
                end else begin
                    err_seen <= drop;
                    wr_ptr   <= wr_ptr + 1'b1;
                end
            end
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

/* design/chdr_out_arbiter.sv */
`timescale 1ns/1ns
// round robin between the two gates, switching only between packets
module chdr_out_arbiter (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  chdr_pkg::axis_beat_t  i_beat0,
    input  logic                  i_valid0,
    output logic                  o_ready0,
    input  chdr_pkg::axis_beat_t  i_beat1,
    input  logic                  i_valid1,
    output logic                  o_ready1,
    output chdr_pkg::axis_beat_t  o_beat,
    output logic                  o_valid,
    input  logic                  i_ready,
    output logic                  o_src
);

    logic busy;         // a packet has been offered and is not finished
    logic grant;        // channel in progress, or the one served last
    logic pick;         // choice for a new packet
    logic sel;

    // last served channel loses a tie
    always_comb begin
        if (i_valid0 && i_valid1)
            pick = ~grant;
        else
            pick = i_valid1;
    end

    assign sel   = busy ? grant : pick;
    assign o_src = sel;

    // plain mux, no added latency
    assign o_valid  = sel ? i_valid1 : i_valid0;
    assign o_beat   = sel ? i_beat1 : i_beat0;
    assign o_ready0 = i_ready && !sel;      // only the granted gate sees ready
    assign o_ready1 = i_ready && sel;

    // lock the grant as soon as a beat is offered so a stalled
    // beat cannot be swapped for the other channel
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy  <= 1'b0;
            grant <= 1'b1;                  // channel 0 wins the first tie
        end else if (o_valid) begin
            grant <= sel;
            busy  <= !(i_ready && o_beat.last);
        end
    end

endmodule

/* design/chdr_err_regs.sv */
`timescale 1ns/1ns
// apb register block
// per channel error counters and the global clear
module chdr_err_regs (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  chdr_pkg::apb_req_t    i_apb,
    output chdr_pkg::chdr_word_t  o_prdata,
    output logic                  o_pready,
    output logic                  o_pslverr,
    input  chdr_pkg::err_pulse_t  i_err0,
    input  chdr_pkg::err_pulse_t  i_err1,
    output logic                  o_clear
);

    chdr_pkg::err_pulse_t err_in  [2];
    chdr_pkg::cnt_t       len_cnt [2];
    chdr_pkg::cnt_t       eof_cnt [2];
    chdr_pkg::cnt_t       seq_cnt [2];
    chdr_pkg::cnt_t       rd_cnt;

    logic access;       // apb access phase
    logic mapped;
    logic clear_q;

    // stops at 0xffff
    function automatic chdr_pkg::cnt_t sat_inc(input chdr_pkg::cnt_t cnt, input logic hit);
        if (hit && (cnt != 16'hFFFF))
            return cnt + 16'd1;
        return cnt;
    endfunction

    assign err_in[0] = i_err0;
    assign err_in[1] = i_err1;

    assign access   = i_apb.psel && i_apb.penable;
    assign o_pready = 1'b1;                 // no wait states
    assign o_clear  = clear_q;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            clear_q <= 1'b0;
            for (int ch = 0; ch < 2; ch++) begin
                len_cnt[ch] <= '0;
                eof_cnt[ch] <= '0;
                seq_cnt[ch] <= '0;
            end
        end else begin
            // one cycle pulse the cycle after the write
            clear_q <= access && i_apb.pwrite && i_apb.pwdata[0] &&
                       (i_apb.paddr == chdr_pkg::ADDR_CTRL);
            for (int ch = 0; ch < 2; ch++) begin
                if (clear_q) begin
                    len_cnt[ch] <= '0;
                    eof_cnt[ch] <= '0;
                    seq_cnt[ch] <= '0;
                end else begin
                    len_cnt[ch] <= sat_inc(len_cnt[ch], err_in[ch].len_err);
                    eof_cnt[ch] <= sat_inc(eof_cnt[ch], err_in[ch].eof_err);
                    seq_cnt[ch] <= sat_inc(seq_cnt[ch], err_in[ch].seq_err);
                end
            end
        end
    end

    // read decode
    always_comb begin
        rd_cnt = '0;
        mapped = 1'b1;
        case (i_apb.paddr)
            chdr_pkg::ADDR_CTRL:    rd_cnt = '0;    // clear bit reads back 0
            chdr_pkg::ADDR_CH0_LEN: rd_cnt = len_cnt[0];
            chdr_pkg::ADDR_CH0_EOF: rd_cnt = eof_cnt[0];
            chdr_pkg::ADDR_CH0_SEQ: rd_cnt = seq_cnt[0];
            chdr_pkg::ADDR_CH1_LEN: rd_cnt = len_cnt[1];
            chdr_pkg::ADDR_CH1_EOF: rd_cnt = eof_cnt[1];
            chdr_pkg::ADDR_CH1_SEQ: rd_cnt = seq_cnt[1];
            default:                mapped = 1'b0;
        endcase
    end

    assign o_prdata  = (access && !i_apb.pwrite) ? {16'h0000, rd_cnt} : '0;
    assign o_pslverr = access && !mapped;   // unmapped reads give zero data

endmodule

/* design/chdr_ingress_top.sv */
`timescale 1ns/1ns
// two channel ingress checker
// checker and gate per channel, one shared output, apb error counters
module chdr_ingress_top #(
    parameter int SIZE = 9                  // max packet and gate depth, 2**SIZE words
) (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  chdr_pkg::axis_beat_t  i_s_beat  [2],
    input  logic                  i_s_valid [2],
    output logic                  o_s_ready [2],
    output chdr_pkg::axis_beat_t  o_m_beat,
    output logic                  o_m_valid,
    output logic                  o_m_src,
    input  logic                  i_m_ready,
    input  chdr_pkg::apb_req_t    i_apb,
    output chdr_pkg::chdr_word_t  o_prdata,
    output logic                  o_pready,
    output logic                  o_pslverr,
    output logic                  o_bus_error
);

    chdr_pkg::axis_beat_t chk_beat   [2];   // checker to gate
    logic                 chk_valid  [2];
    logic                 chk_ready  [2];
    chdr_pkg::axis_beat_t gate_beat  [2];   // gate to arbiter
    logic                 gate_valid [2];
    logic                 gate_ready [2];
    chdr_pkg::err_pulse_t err        [2];
    logic                 clear;

    for (genvar ch = 0; ch < 2; ch++) begin : g_ch
        chdr_frame_checker #(.SIZE(SIZE)) u_checker (
            .clk     (clk),
            .i_rst_n (i_rst_n),
            .i_clear (clear),
            .i_beat  (i_s_beat[ch]),
            .i_valid (i_s_valid[ch]),
            .o_ready (o_s_ready[ch]),
            .o_beat  (chk_beat[ch]),
            .o_valid (chk_valid[ch]),
            .i_ready (chk_ready[ch]),
            .o_err   (err[ch])
        );

        chdr_packet_gate #(.SIZE(SIZE)) u_gate (
            .clk     (clk),
            .i_rst_n (i_rst_n),
            .i_clear (clear),
            .i_beat  (chk_beat[ch]),
            .i_valid (chk_valid[ch]),
            .o_ready (chk_ready[ch]),
            .o_beat  (gate_beat[ch]),
            .o_valid (gate_valid[ch]),
            .i_ready (gate_ready[ch])
        );
    end

    chdr_out_arbiter u_arbiter (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_beat0  (gate_beat[0]),
        .i_valid0 (gate_valid[0]),
        .o_ready0 (gate_ready[0]),
        .i_beat1  (gate_beat[1]),
        .i_valid1 (gate_valid[1]),
        .o_ready1 (gate_ready[1]),
        .o_beat   (o_m_beat),
        .o_valid  (o_m_valid),
        .i_ready  (i_m_ready),
        .o_src    (o_m_src)
    );

    chdr_err_regs u_regs (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_apb     (i_apb),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr),
        .i_err0    (err[0]),
        .i_err1    (err[1]),
        .o_clear   (clear)
    );

    // alignment problems only, sequence gaps are just counted
    assign o_bus_error = err[0].len_err | err[0].eof_err |
                         err[1].len_err | err[1].eof_err;

endmodule

/* bench/chdr_ingress_asserts.sv */
`timescale 1ns/1ns
// handshake properties of the ingress top, bound into chdr_ingress_top
module chdr_ingress_asserts (
    input logic                     clk,
    input logic                     i_rst_n,
    input chdr_pkg::axis_beat_t     i_m_beat,   // top output beat
    input logic                     i_m_valid,
    input logic                     i_m_src,
    input logic                     i_m_ready,
    input chdr_pkg::apb_req_t       i_apb,
    input logic                     i_pready,
    input chdr_pkg::checker_state_e i_state0,   // channel 0 checker FSM
    input chdr_pkg::checker_state_e i_state1
);

    // a stalled output beat keeps its data and its source
    a_hold_beat: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_m_valid && !i_m_ready |=> i_m_valid && $stable(i_m_beat) && $stable(i_m_src))
        else $error("output beat changed while stalled");

    // no grant change inside a packet
    a_hold_grant: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_m_valid && i_m_ready && !i_m_beat.last |=> i_m_src == $past(i_m_src))
        else $error("grant switched in the middle of a packet");

    a_pready: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_apb.psel && i_apb.penable |-> i_pready)   // zero wait state slave
        else $error("pready low in an access phase");

    // both FSMs idle once reset is released
    a_reset_state: assert property (@(posedge clk)
        $rose(i_rst_n) |-> (i_state0 == chdr_pkg::HDR) && (i_state1 == chdr_pkg::HDR))
        else $error("checker not in HDR after reset");

endmodule

bind chdr_ingress_top chdr_ingress_asserts u_asserts (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_m_beat  (o_m_beat),
    .i_m_valid (o_m_valid),
    .i_m_src   (o_m_src),
    .i_m_ready (i_m_ready),
    .i_apb     (i_apb),
    .i_pready  (o_pready),
    .i_state0  (g_ch[0].u_checker.state),
    .i_state1  (g_ch[1].u_checker.state)
);

/* bench/chdr_ingress_tb.sv */
`timescale 1ns/1ns
// directed testbench for the two channel ingress checker
module chdr_ingress_tb;

    localparam int SIZE       = 4;          // 16 word packets at most
    localparam int MAX_CYCLES = 20000;      // tests need about 3000 cycles

    logic                 clk = 1'b0;
    logic                 rst_n;
    chdr_pkg::axis_beat_t s_beat  [2];
    logic                 s_valid [2];
    logic                 s_ready [2];
    chdr_pkg::axis_beat_t m_beat;
    logic                 m_valid;
    logic                 m_src;
    logic                 m_ready;
    chdr_pkg::apb_req_t   apb;
    chdr_pkg::chdr_word_t prdata;
    logic                 pready;
    logic                 pslverr;
    logic                 bus_error;

    chdr_pkg::axis_beat_t exp_q0 [$];       // expected output words, channel 0
    chdr_pkg::axis_beat_t exp_q1 [$];
    chdr_pkg::cnt_t       exp_len [2];      // reference error counts
    chdr_pkg::cnt_t       exp_eof [2];
    chdr_pkg::cnt_t       exp_seq [2];
    chdr_pkg::seq_t       seq_next [2];     // reference expected sequence number
    logic                 rand_ready;       // randomize i_m_ready
    logic                 in_pkt;           // output is inside a packet
    logic                 cur_src;
    int                   cycles = 0;

    chdr_ingress_top #(.SIZE(SIZE)) uut (
        .clk         (clk),
        .i_rst_n     (rst_n),
        .i_s_beat    (s_beat),
        .i_s_valid   (s_valid),
        .o_s_ready   (s_ready),
        .o_m_beat    (m_beat),
        .o_m_valid   (m_valid),
        .o_m_src     (m_src),
        .i_m_ready   (m_ready),
        .i_apb       (apb),
        .o_prdata    (prdata),
        .o_pready    (pready),
        .o_pslverr   (pslverr),
        .o_bus_error (bus_error)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout after %0d cycles, the DUT stopped responding", MAX_CYCLES);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_beat(input chdr_pkg::axis_beat_t got,
                                input chdr_pkg::axis_beat_t want, input string name);
        if (got !== want) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, want);
            abort_run();
        end
    endtask

    task automatic compare_cnt(input chdr_pkg::cnt_t got, input chdr_pkg::cnt_t want,
                               input string name);
        if (got !== want) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, want);
            abort_run();
        end
    endtask

    task automatic compare_bit(input logic got, input logic want, input string name);
        if (got !== want) begin
            $display("ERR %0t %s got %b expected %b", $time, name, got, want);
            abort_run();
        end
    endtask

    task automatic push_exp(input int ch, input chdr_pkg::axis_beat_t beat);
        if (ch == 0)
            exp_q0.push_back(beat);
        else
            exp_q1.push_back(beat);
    endtask

    // called on a falling edge, returns there once the word was taken
    task automatic send_word(input int ch, input chdr_pkg::axis_beat_t beat, output logic err);
        logic taken;
        s_beat[ch]  = beat;
        s_valid[ch] = 1'b1;
        do begin
            #1;                             // ready and error settle after the drive
            taken = s_ready[ch];
            err   = bus_error;              // pulse belongs to this transfer
            @(negedge clk);
        end while (!taken);
    endtask

    task automatic send_packet(input int ch, input int nwords, input chdr_pkg::seq_t seq);
        chdr_pkg::axis_beat_t beat;
        logic                 err;
        for (int i = 0; i < nwords; i++) begin
            if (i == 0)
                beat.data = {4'(ch), seq, 16'(nwords * 4 - 3)};  // channel tag in unused bits
            else
                beat.data = $urandom;
            beat.last = (i == nwords - 1);
            beat.err  = 1'b0;
            push_exp(ch, beat);
            send_word(ch, beat, err);
        end
        s_valid[ch] = 1'b0;
        if (seq != seq_next[ch])
            exp_seq[ch]++;                  // gap is counted, packet still goes out
        seq_next[ch] = seq + 12'd1;
    endtask

    // bad header plus ntail words, last flag on the final one
    task automatic send_bad_length(input int ch, input chdr_pkg::len_t bytes, input int ntail);
        chdr_pkg::axis_beat_t beat;
        logic                 err;
        beat.data = {4'h0, seq_next[ch], bytes};
        beat.last = 1'b0;
        beat.err  = 1'b0;
        send_word(ch, beat, err);
        compare_bit(err, 1'b1, "o_bus_error");
        for (int i = 0; i < ntail; i++) begin
            beat.data = $urandom;
            beat.last = (i == ntail - 1);
            send_word(ch, beat, err);
        end
        s_valid[ch] = 1'b0;
        exp_len[ch]++;
    endtask

    // word nwords has no last flag, ntail more words close the frame
    task automatic send_missing_last(input int ch, input int nwords, input int ntail);
        chdr_pkg::axis_beat_t beat;
        logic                 err;
        beat.err = 1'b0;
        for (int i = 0; i < nwords + ntail; i++) begin
            beat.data = (i == 0) ? {4'h0, seq_next[ch], 16'(nwords * 4)} : $urandom;
            beat.last = (i == nwords + ntail - 1);
            send_word(ch, beat, err);
            if (i == nwords - 1)
                compare_bit(err, 1'b1, "o_bus_error");
        end
        s_valid[ch] = 1'b0;
        exp_eof[ch]++;
        seq_next[ch] = seq_next[ch] + 12'd1;    // header itself was accepted
    endtask

    task automatic check_output();
        chdr_pkg::axis_beat_t want;
        if (in_pkt && (m_src != cur_src)) begin
            $display("packets of the two channels were interleaved at %0t", $time);
            abort_run();
        end
        if ((m_src ? exp_q1.size() : exp_q0.size()) == 0) begin
            $display("channel %0d put out a word that was not expected at %0t", m_src, $time);
            abort_run();
        end
        if (m_src)
            want = exp_q1.pop_front();
        else
            want = exp_q0.pop_front();
        compare_beat(m_beat, want, "o_m_beat");
        in_pkt  = !m_beat.last;
        cur_src = m_src;
    endtask

    // i_m_ready pattern, a new value on every falling edge
    task automatic drive_ready();
        forever begin
            @(negedge clk);
            if (rand_ready)
                m_ready = ($urandom % 4) != 0;
            else
                m_ready = 1'b1;
        end
    endtask

    // output side, the beat is checked before the next rising edge
    always @(negedge clk) begin
        #1;
        if (m_valid && m_ready)
            check_output();
    end

    task automatic wait_drain();
        while ((exp_q0.size() != 0) || (exp_q1.size() != 0))
            @(negedge clk);
    endtask

    task automatic apb_access(input logic write, input chdr_pkg::apb_addr_t addr,
                              input chdr_pkg::chdr_word_t wdata,
                              output chdr_pkg::chdr_word_t rdata, output logic slverr);
        apb.psel    = 1'b1;                 // setup phase
        apb.penable = 1'b0;
        apb.pwrite  = write;
        apb.paddr   = addr;
        apb.pwdata  = wdata;
        @(negedge clk);
        apb.penable = 1'b1;
        #1;
        rdata  = prdata;
        slverr = pslverr;
        compare_bit(pready, 1'b1, "o_pready");  // no wait states
        @(negedge clk);
        apb.psel    = 1'b0;
        apb.penable = 1'b0;
    endtask

    task automatic read_count(input chdr_pkg::apb_addr_t addr, input chdr_pkg::cnt_t want,
                              input string name);
        chdr_pkg::chdr_word_t rdata;
        logic                 slverr;
        apb_access(1'b0, addr, '0, rdata, slverr);
        compare_bit(slverr, 1'b0, "o_pslverr");
        compare_cnt(rdata[31:16], 16'h0000, "o_prdata upper half");
        compare_cnt(rdata[15:0], want, name);
    endtask

    task automatic check_counters();
        read_count(chdr_pkg::ADDR_CH0_LEN, exp_len[0], "ch0 len count");
        read_count(chdr_pkg::ADDR_CH0_EOF, exp_eof[0], "ch0 eof count");
        read_count(chdr_pkg::ADDR_CH0_SEQ, exp_seq[0], "ch0 seq count");
        read_count(chdr_pkg::ADDR_CH1_LEN, exp_len[1], "ch1 len count");
        read_count(chdr_pkg::ADDR_CH1_EOF, exp_eof[1], "ch1 eof count");
        read_count(chdr_pkg::ADDR_CH1_SEQ, exp_seq[1], "ch1 seq count");
    endtask

    task automatic test_valid_packets();
        fork
            begin
                send_packet(0, 1, 12'd0);
                send_packet(0, 2, 12'd1);
                send_packet(0, 16, 12'd2);
            end
            begin
                send_packet(1, 1, 12'd0);
                send_packet(1, 2, 12'd1);
                send_packet(1, 16, 12'd2);
            end
        join
        wait_drain();
        check_counters();
    endtask

    task automatic test_bad_length();
        send_bad_length(0, 16'd0, 2);       // zero words
        send_bad_length(0, 16'd400, 3);     // 100 words, over the limit
        send_packet(0, 3, seq_next[0]);
        wait_drain();
        check_counters();
    endtask

    task automatic test_missing_eof();
        send_missing_last(1, 5, 2);
        send_packet(1, 4, seq_next[1]);
        wait_drain();
        check_counters();
    endtask

    task automatic test_seq_gap();
        chdr_pkg::seq_t base;
        base = seq_next[0];
        send_packet(0, 2, base);
        send_packet(0, 2, base + 12'd1);
        send_packet(0, 2, base + 12'd5);    // one gap
        send_packet(0, 2, base + 12'd6);
        wait_drain();
        check_counters();
    endtask

    task automatic test_random_ready();
        rand_ready = 1'b1;
        fork
            for (int n = 0; n < 20; n++)
                send_packet(0, 1 + $urandom % 16, seq_next[0]);
            for (int n = 0; n < 20; n++)
                send_packet(1, 1 + $urandom % 16, seq_next[1]);
        join
        wait_drain();
        rand_ready = 1'b0;
        check_counters();
    endtask

    task automatic test_regs();
        chdr_pkg::chdr_word_t rdata;
        logic                 slverr;
        apb_access(1'b0, 8'h1C, '0, rdata, slverr);
        compare_bit(slverr, 1'b1, "o_pslverr");
        compare_cnt(rdata[15:0], 16'h0000, "o_prdata unmapped");
        apb_access(1'b0, 8'h40, '0, rdata, slverr);
        compare_bit(slverr, 1'b1, "o_pslverr");
        apb_access(1'b1, chdr_pkg::ADDR_CTRL, 32'h1, rdata, slverr);
        for (int ch = 0; ch < 2; ch++) begin
            exp_len[ch]  = '0;
            exp_eof[ch]  = '0;
            exp_seq[ch]  = '0;
            seq_next[ch] = '0;              // checkers restart from 0
        end
        check_counters();                   // clear pulse is over by now
        fork
            send_packet(0, 2, 12'd0);
            send_packet(1, 3, 12'd0);
        join
        wait_drain();
        check_counters();
    endtask

    initial begin
        void'($urandom(32'hfb48));
        rst_n      = 1'b0;
        m_ready    = 1'b0;
        rand_ready = 1'b0;
        in_pkt     = 1'b0;
        cur_src    = 1'b0;
        apb        = '0;
        for (int ch = 0; ch < 2; ch++) begin
            s_beat[ch]   = '0;
            s_valid[ch]  = 1'b0;
            exp_len[ch]  = '0;
            exp_eof[ch]  = '0;
            exp_seq[ch]  = '0;
            seq_next[ch] = '0;
        end
        fork
            drive_ready();
        join_none
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_valid_packets();
        test_bad_length();
        test_missing_eof();
        test_seq_gap();
        test_random_ready();
        test_regs();
        if ((exp_q0.size() != 0) || (exp_q1.size() != 0)) begin
            $display("words were still expected at the end of the run");
            abort_run();
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

/* files.f */
design/chdr_pkg.sv
design/chdr_frame_checker.sv
design/chdr_packet_gate.sv
design/chdr_out_arbiter.sv
design/chdr_err_regs.sv
design/chdr_ingress_top.sv
bench/chdr_ingress_asserts.sv
bench/chdr_ingress_tb.sv
